// ==== verilog/sifh_geometry_pkg.sv ====
package sifh_geometry_pkg;

    // Arrival time word and the bins cut from its top bits.
    localparam int DEF_DATA_BITS  = 8;
    localparam int DEF_BIN_BITS   = 4;    // 16 bins per pixel.

    // Sensor row and frame shape.
    localparam int DEF_PIXEL_NUM  = 4;
    localparam int DEF_DATA_NUM   = 2;    // Words per pixel visit.
    localparam int DEF_ACQ_NUM    = 8;    // Passes over the row per frame.

    // Bin counters stop at their maximum value.
    localparam int DEF_COUNT_BITS = 8;

    // Width of an index over n items, never below one bit.
    function automatic int sifh_idx_bits(input int n);
        if (n > 1) begin
            return $clog2(n);
        end
        return 1;
    endfunction

endpackage

// ==== verilog/sifh_ctrl_pkg.sv ====
package sifh_ctrl_pkg;

    typedef enum logic [1:0] {
        idle      = 2'b00,    // Waiting for the first word of a frame.
        build_his = 2'b01,    // Words go into the histogram.
        drain     = 2'b10,    // Incrementer pipeline empties.
        find_peak = 2'b11     // Bins are scanned and cleared.
    } sifh_state_t;

    // How the histogram bank treats its two access ports.
    typedef enum logic {
        accumulate = 1'b0,
        scan       = 1'b1
    } bank_mode_t;

endpackage

// ==== verilog/sifh_control.sv ====
`timescale 1ns/10ps

module sifh_control
    import sifh_geometry_pkg::*;
    import sifh_ctrl_pkg::*;
#(
    parameter int DATA_BITS  = DEF_DATA_BITS,
    parameter int BIN_BITS   = DEF_BIN_BITS,
    parameter int PIXEL_NUM  = DEF_PIXEL_NUM,
    parameter int DATA_NUM   = DEF_DATA_NUM,
    parameter int ACQ_NUM    = DEF_ACQ_NUM,
    localparam int PIX_BITS  = sifh_idx_bits(PIXEL_NUM)
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 wr_en,
    input  logic [DATA_BITS-1:0] data,
    input  logic                 scan_done,
    output logic                 inc_en,
    output logic [PIX_BITS-1:0]  inc_pixel,
    output logic [BIN_BITS-1:0]  bin,
    output bank_mode_t           mode,
    output logic                 scan_start,
    output logic                 busy
);

    localparam int WORD_BITS = sifh_idx_bits(DATA_NUM);
    localparam int ACQ_BITS  = sifh_idx_bits(ACQ_NUM);

    sifh_state_t state;
    sifh_state_t state_nx;

    logic [WORD_BITS-1:0] word_cnt;
    logic [PIX_BITS-1:0]  pixel_cnt;
    logic [ACQ_BITS-1:0]  acq_cnt;
    logic                 drain_cnt;

    logic accept;
    logic word_last;
    logic pixel_last;
    logic acq_last;
    logic last_word;

    assign accept     = wr_en && ((state == idle) || (state == build_his));
    assign word_last  = (word_cnt == WORD_BITS'(DATA_NUM - 1));
    assign pixel_last = (pixel_cnt == PIX_BITS'(PIXEL_NUM - 1));
    assign acq_last   = (acq_cnt == ACQ_BITS'(ACQ_NUM - 1));
    assign last_word  = word_last && pixel_last && acq_last;    // Closes the frame.

    always_comb begin
        state_nx = state;
        case (state)
            idle: begin
                if (accept) begin
                    state_nx = last_word ? drain : build_his;
                end
            end
            build_his: begin
                if (accept && last_word) begin
                    state_nx = drain;
                end
            end
            drain: begin
                if (drain_cnt) begin
                    state_nx = find_peak;
                end
            end
            find_peak: begin
                if (scan_done) begin
                    state_nx = idle;
                end
            end
            default: begin
                state_nx = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= idle;
            drain_cnt  <= 1'b0;
            scan_start <= 1'b0;
        end else begin
            state      <= state_nx;
            drain_cnt  <= (state == drain) ? ~drain_cnt : 1'b0;    // Two drain cycles.
            scan_start <= (state == drain) && drain_cnt;
        end
    end

    // Word, pixel and pass counters move on accepted words only.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            word_cnt  <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
        end else if (accept) begin
            if (word_last) begin
                word_cnt <= '0;
                if (pixel_last) begin
                    pixel_cnt <= '0;
                    acq_cnt   <= acq_last ? '0 : acq_cnt + 1'b1;
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    assign inc_en    = accept;
    assign inc_pixel = pixel_cnt;
    assign bin       = data[DATA_BITS-1 -: BIN_BITS];    // Top bits pick the time bin.
    assign mode      = (state == find_peak) ? scan : accumulate;
    assign busy      = (state != idle);

endmodule

// ==== verilog/hist_bank.sv ====
`timescale 1ns/10ps

module hist_bank
    import sifh_geometry_pkg::*;
    import sifh_ctrl_pkg::*;
#(
    parameter int PIXEL_NUM  = DEF_PIXEL_NUM,
    parameter int BIN_BITS   = DEF_BIN_BITS,
    parameter int COUNT_BITS = DEF_COUNT_BITS,
    localparam int PIX_BITS  = sifh_idx_bits(PIXEL_NUM),
    localparam int ADDR_BITS = PIX_BITS + BIN_BITS
) (
    input  logic                  clk,
    input  logic                  res,
    input  bank_mode_t            mode,
    input  logic                  inc_en,
    input  logic [PIX_BITS-1:0]   inc_pixel,
    input  logic [BIN_BITS-1:0]   bin,
    input  logic                  scan_en,
    input  logic [ADDR_BITS-1:0]  scan_addr,
    output logic [COUNT_BITS-1:0] rd_count,
    output logic                  rd_valid
);

    localparam int DEPTH = PIXEL_NUM << BIN_BITS;    // One row of bins per pixel.

    logic [COUNT_BITS-1:0] mem [DEPTH];

    logic                  inc_go;
    logic                  scan_go;
    logic [ADDR_BITS-1:0]  inc_addr;
    logic                  fwd;
    logic [COUNT_BITS-1:0] base_count;

    // Second stage of the incrementer holds the value to write back.
    logic                  upd_valid;
    logic [ADDR_BITS-1:0]  upd_addr;
    logic [COUNT_BITS-1:0] upd_count;

    function automatic logic [COUNT_BITS-1:0] sat_inc(input logic [COUNT_BITS-1:0] c);
        if (&c) begin
            return c;    // Full counts stay full.
        end
        return c + 1'b1;
    endfunction

    assign inc_go   = inc_en && (mode == accumulate);
    assign scan_go  = scan_en && (mode == scan);
    assign inc_addr = {inc_pixel, bin};

    // A hit on the bin still in flight must see its new count.
    assign fwd        = upd_valid && (upd_addr == inc_addr);
    assign base_count = fwd ? upd_count : mem[inc_addr];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            upd_valid <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            upd_valid <= inc_go;
            rd_valid  <= scan_go;
        end
    end

    always_ff @(posedge clk) begin
        if (inc_go) begin
            upd_addr  <= inc_addr;
            upd_count <= sat_inc(base_count);
        end
        if (scan_go) begin
            rd_count <= mem[scan_addr];
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (scan_go) begin
            mem[scan_addr] <= '0;    // Read and clear in one access.
        end else if (upd_valid) begin
            mem[upd_addr] <= upd_count;
        end
    end

endmodule

// ==== verilog/peak_finder.sv ====
`timescale 1ns/10ps

module peak_finder
    import sifh_geometry_pkg::*;
#(
    parameter int PIXEL_NUM  = DEF_PIXEL_NUM,
    parameter int BIN_BITS   = DEF_BIN_BITS,
    parameter int COUNT_BITS = DEF_COUNT_BITS,
    localparam int PIX_BITS  = sifh_idx_bits(PIXEL_NUM),
    localparam int ADDR_BITS = PIX_BITS + BIN_BITS
) (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          scan_start,
    input  logic [COUNT_BITS-1:0]         rd_count,
    input  logic                          rd_valid,
    output logic                          scan_en,
    output logic [ADDR_BITS-1:0]          scan_addr,
    output logic [PIXEL_NUM*BIN_BITS-1:0] peaks,
    output logic                          scan_done
);

    logic [PIX_BITS-1:0]   scan_pix;
    logic [BIN_BITS-1:0]   scan_bin;
    logic                  scan_last;

    // Address of the count that arrives on rd_count.
    logic [PIX_BITS-1:0]   rd_pix;
    logic [BIN_BITS-1:0]   rd_bin;
    logic                  rd_last_bin;
    logic                  rd_last_pix;

    logic [COUNT_BITS-1:0] best_count;
    logic [BIN_BITS-1:0]   best_bin;
    logic                  take;
    logic [COUNT_BITS-1:0] next_count;
    logic [BIN_BITS-1:0]   next_bin;

    assign scan_addr = {scan_pix, scan_bin};
    assign scan_last = (scan_pix == PIX_BITS'(PIXEL_NUM - 1)) && (&scan_bin);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scan_en  <= 1'b0;
            scan_pix <= '0;
            scan_bin <= '0;
        end else if (scan_start) begin
            scan_en  <= 1'b1;
            scan_pix <= '0;
            scan_bin <= '0;
        end else if (scan_en) begin
            scan_bin <= scan_bin + 1'b1;
            if (&scan_bin) begin
                scan_pix <= scan_pix + 1'b1;
            end
            if (scan_last) begin
                scan_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_en) begin
            {rd_pix, rd_bin} <= scan_addr;    // Lines up with the bank read.
        end
        if (rd_valid) begin
            best_count <= next_count;
            best_bin   <= next_bin;
        end
    end

    assign rd_last_bin = &rd_bin;
    assign rd_last_pix = (rd_pix == PIX_BITS'(PIXEL_NUM - 1));

    // Bin 0 opens a pixel; later bins win only when strictly larger.
    assign take       = (rd_bin == '0) || (rd_count > best_count);
    assign next_count = take ? rd_count : best_count;
    assign next_bin   = take ? rd_bin : best_bin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peaks     <= '0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= rd_valid && rd_last_bin && rd_last_pix;
            if (rd_valid && rd_last_bin) begin
                peaks[rd_pix*BIN_BITS +: BIN_BITS] <= next_bin;
            end
        end
    end

endmodule

// ==== verilog/sifh_top.sv ====
`timescale 1ns/10ps

module sifh_top
    import sifh_geometry_pkg::*;
    import sifh_ctrl_pkg::*;
#(
    parameter int DATA_BITS  = DEF_DATA_BITS,
    parameter int BIN_BITS   = DEF_BIN_BITS,
    parameter int PIXEL_NUM  = DEF_PIXEL_NUM,
    parameter int DATA_NUM   = DEF_DATA_NUM,
    parameter int ACQ_NUM    = DEF_ACQ_NUM,
    parameter int COUNT_BITS = DEF_COUNT_BITS,
    localparam int PIX_BITS  = sifh_idx_bits(PIXEL_NUM),
    localparam int ADDR_BITS = PIX_BITS + BIN_BITS
) (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          wr_en,
    input  logic [DATA_BITS-1:0]          data,
    output logic                          busy,
    output logic [PIXEL_NUM*BIN_BITS-1:0] peaks,
    output logic                          peaks_valid
);

    logic                  inc_en;
    logic [PIX_BITS-1:0]   inc_pixel;
    logic [BIN_BITS-1:0]   bin;
    bank_mode_t            mode;
    logic                  scan_start;
    logic                  scan_en;
    logic [ADDR_BITS-1:0]  scan_addr;
    logic [COUNT_BITS-1:0] rd_count;
    logic                  rd_valid;
    logic                  scan_done;

    sifh_control #(
        .DATA_BITS (DATA_BITS),
        .BIN_BITS  (BIN_BITS),
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) sifh_control_inst (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .data       (data),
        .scan_done  (scan_done),
        .inc_en     (inc_en),
        .inc_pixel  (inc_pixel),
        .bin        (bin),
        .mode       (mode),
        .scan_start (scan_start),
        .busy       (busy)
    );

    hist_bank #(
        .PIXEL_NUM  (PIXEL_NUM),
        .BIN_BITS   (BIN_BITS),
        .COUNT_BITS (COUNT_BITS)
    ) hist_bank_inst (
        .clk       (clk),
        .res       (res),
        .mode      (mode),
        .inc_en    (inc_en),
        .inc_pixel (inc_pixel),
        .bin       (bin),
        .scan_en   (scan_en),
        .scan_addr (scan_addr),
        .rd_count  (rd_count),
        .rd_valid  (rd_valid)
    );

    peak_finder #(
        .PIXEL_NUM  (PIXEL_NUM),
        .BIN_BITS   (BIN_BITS),
        .COUNT_BITS (COUNT_BITS)
    ) peak_finder_inst (
        .clk        (clk),
        .res        (res),
        .scan_start (scan_start),
        .rd_count   (rd_count),
        .rd_valid   (rd_valid),
        .scan_en    (scan_en),
        .scan_addr  (scan_addr),
        .peaks      (peaks),
        .scan_done  (scan_done)
    );

    assign peaks_valid = scan_done;    // The end of the scan marks the peaks valid.

endmodule

// ==== test/sifh_properties.sv ====
`timescale 1ns/10ps

module sifh_properties
    import sifh_ctrl_pkg::*;
(
    input logic        clk,
    input logic        res,
    input sifh_state_t state,
    input bank_mode_t  mode,
    input logic        inc_en,
    input logic        scan_start,
    input logic        busy,
    input logic        scan_en,
    input logic        rd_valid
);

    // The bank takes no increment while its bins are scanned.
    inc_outside_scan: assert property (@(posedge clk) disable iff (!res)
        inc_en |-> (mode == accumulate))
        else $error("inc_en raised while the bank is in scan mode");

    // The scan starts after exactly two drain cycles.
    start_after_drain: assert property (@(posedge clk) disable iff (!res)
        scan_start |-> ($past(state) == drain) && ($past(state, 2) == drain)
                       && ($past(state, 3) != drain))
        else $error("scan_start not preceded by exactly two drain cycles");

    start_single: assert property (@(posedge clk) disable iff (!res)
        scan_start |=> !scan_start)
        else $error("scan_start longer than one cycle");

    read_follows_scan: assert property (@(posedge clk) disable iff (!res)
        rd_valid == $past(scan_en))
        else $error("rd_valid does not follow scan_en by one cycle");

    idle_after_reset: assert property (@(posedge clk) $rose(res) |-> !busy)
        else $error("busy high right after reset");

endmodule

bind sifh_control sifh_properties ctrl_props_inst (
    .clk(clk), .res(res), .state(state), .mode(sifh_ctrl_pkg::accumulate), .inc_en(1'b0),
    .scan_start(scan_start), .busy(busy), .scan_en(1'b0), .rd_valid(1'b0)
);

bind hist_bank sifh_properties bank_props_inst (
    .clk(clk), .res(res), .state(sifh_ctrl_pkg::idle), .mode(mode), .inc_en(inc_en),
    .scan_start(1'b0), .busy(1'b0), .scan_en(scan_en), .rd_valid(rd_valid)
);

// ==== test/sifh_top_tb.sv ====
`timescale 1ns/10ps

module sifh_top_tb
    import sifh_geometry_pkg::*;
();

    localparam int DATA_BITS      = DEF_DATA_BITS;
    localparam int BIN_BITS       = DEF_BIN_BITS;
    localparam int PIXEL_NUM      = DEF_PIXEL_NUM;
    localparam int DATA_NUM       = DEF_DATA_NUM;
    localparam int ACQ_NUM        = DEF_ACQ_NUM;
    localparam int NBINS          = 1 << BIN_BITS;
    localparam int PEAK_BITS      = PIXEL_NUM * BIN_BITS;
    localparam int FRAME_WORDS    = PIXEL_NUM * DATA_NUM * ACQ_NUM;
    localparam int SAT_COUNT_BITS = 3;    // Small counters so a frame can saturate a bin.
    localparam int LATENCY        = 2 + 1 + PIXEL_NUM * NBINS + 2;
    localparam int TIMEOUT        = 4 * LATENCY;

    typedef logic [DATA_BITS-1:0] frame_t [FRAME_WORDS];

    logic                 clk;
    logic                 res;
    logic                 wr_en;
    logic [DATA_BITS-1:0] data;
    logic                 busy;
    logic [PEAK_BITS-1:0] peaks;
    logic                 peaks_valid;
    logic                 sat_busy;
    logic [PEAK_BITS-1:0] sat_peaks;
    logic                 sat_peaks_valid;

    int     seed = 32'h117c;
    frame_t frame;
    logic [PEAK_BITS-1:0] exp_peaks;
    logic [PEAK_BITS-1:0] exp_sat_peaks;
    int     cyc = 0;
    int     last_cyc = 0;
    int     valid_count = 0;
    int     sat_valid_count = 0;
    int     frames_sent = 0;

    sifh_top sifh_top_inst (
        .clk         (clk),
        .res         (res),
        .wr_en       (wr_en),
        .data        (data),
        .busy        (busy),
        .peaks       (peaks),
        .peaks_valid (peaks_valid)
    );

    sifh_top #(
        .COUNT_BITS (SAT_COUNT_BITS)
    ) sifh_top_sat_inst (
        .clk         (clk),
        .res         (res),
        .wr_en       (wr_en),
        .data        (data),
        .busy        (sat_busy),
        .peaks       (sat_peaks),
        .peaks_valid (sat_peaks_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Value mismatch.");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on timeout.");
    endtask

    // Histogram per pixel with saturating counts, then the first bin of highest count.
    function automatic logic [PEAK_BITS-1:0] ref_peaks(input frame_t words, input int count_bits);
        int cnt [PIXEL_NUM][NBINS];
        int top;
        int pix;
        int b;
        int best;
        logic [PEAK_BITS-1:0] result;
        top = (1 << count_bits) - 1;
        result = '0;
        foreach (cnt[p, k]) begin
            cnt[p][k] = 0;
        end
        for (int i = 0; i < FRAME_WORDS; i++) begin
            pix = (i / DATA_NUM) % PIXEL_NUM;
            b = int'(words[i][DATA_BITS-1 -: BIN_BITS]);
            if (cnt[pix][b] < top) begin
                cnt[pix][b]++;
            end
        end
        for (int p = 0; p < PIXEL_NUM; p++) begin
            best = 0;
            for (int k = 1; k < NBINS; k++) begin
                if (cnt[p][k] > cnt[p][best]) begin
                    best = k;
                end
            end
            result[p*BIN_BITS +: BIN_BITS] = BIN_BITS'(best);
        end
        return result;
    endfunction

    function automatic logic [DATA_BITS-1:0] bin_word(input int b);
        logic [DATA_BITS-1:0] w;
        w = DATA_BITS'($random(seed));    // Low bits are arrival time noise inside the bin.
        w[DATA_BITS-1 -: BIN_BITS] = BIN_BITS'(b);
        return w;
    endfunction

    task automatic make_random_frame();
        for (int i = 0; i < FRAME_WORDS; i++) begin
            frame[i] = DATA_BITS'($random(seed));
        end
    endtask

    // Pixel 0 ties two bins, pixel 2 needs back-to-back hits on one bin to win.
    task automatic make_tie_frame();
        int pix;
        int pass;
        for (int i = 0; i < FRAME_WORDS; i++) begin
            pix = (i / DATA_NUM) % PIXEL_NUM;
            pass = i / (DATA_NUM * PIXEL_NUM);
            case (pix)
                0: frame[i] = bin_word((pass < ACQ_NUM / 2) ? 9 : 5);
                1: frame[i] = bin_word(3);
                2: frame[i] = bin_word((pass < ACQ_NUM / 2) ? 14 : ((i % DATA_NUM == 0) ? 1 : 6));
                default: frame[i] = DATA_BITS'($random(seed));
            endcase
        end
    endtask

    // A wrapping 3 bit counter would let bin 2 win pixel 0 and lose bin 15 on pixel 1.
    task automatic make_sat_frame();
        int pix;
        int pass;
        for (int i = 0; i < FRAME_WORDS; i++) begin
            pix = (i / DATA_NUM) % PIXEL_NUM;
            pass = i / (DATA_NUM * PIXEL_NUM);
            case (pix)
                0: frame[i] = bin_word((pass < ACQ_NUM - 2) ? 10 : 2);
                1: frame[i] = bin_word(15);
                default: frame[i] = DATA_BITS'($random(seed));
            endcase
        end
    endtask

    task automatic run_frame(input bit gaps, input bit junk);
        int gap;
        int waited;
        exp_peaks = ref_peaks(frame, DEF_COUNT_BITS);
        exp_sat_peaks = ref_peaks(frame, SAT_COUNT_BITS);
        frames_sent++;
        for (int i = 0; i < FRAME_WORDS; i++) begin
            gap = gaps ? ($random(seed) & 3) : 0;
            repeat (gap) begin
                @(posedge clk);
                wr_en <= 1'b0;
            end
            @(posedge clk);
            wr_en <= 1'b1;
            data  <= frame[i];
        end
        @(posedge clk);
        last_cyc = cyc;    // Edge on which the last word is taken.
        wr_en <= 1'b0;
        waited = 0;
        while ((valid_count < frames_sent) || (sat_valid_count < frames_sent)) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("peaks_valid");
            end
            if (junk && busy && !peaks_valid) begin
                wr_en <= 1'b1;
                data  <= DATA_BITS'($random(seed));
            end else begin
                wr_en <= 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        check(64'(valid_count), 64'(frames_sent), "peaks_valid pulse count");
        check(64'(sat_valid_count), 64'(frames_sent), "saturating build peaks_valid pulse count");
        check(64'(busy), 64'(0), "busy after the frame");
        check(64'(sat_busy), 64'(0), "saturating build busy after the frame");
    endtask

    always @(posedge clk) begin
        if (res) begin
            if (peaks_valid) begin
                check(64'(busy), 64'(1), "busy with peaks_valid");
                check(64'(peaks), 64'(exp_peaks), "peaks with 8 bit counts");
                check(64'(cyc - last_cyc), 64'(LATENCY), "cycles from last word to peaks_valid");
                valid_count <= valid_count + 1;
            end
            if (sat_peaks_valid) begin
                check(64'(sat_busy), 64'(1), "saturating build busy with peaks_valid");
                check(64'(sat_peaks), 64'(exp_sat_peaks), "peaks with 3 bit counts");
                check(64'(cyc - last_cyc), 64'(LATENCY),
                      "cycles from last word to saturating build peaks_valid");
                sat_valid_count <= sat_valid_count + 1;
            end
        end
    end

    initial begin
        res   = 1'b0;
        wr_en = 1'b0;
        data  = '0;
        repeat (8) @(posedge clk);
        res <= 1'b1;
        @(posedge clk);
        check(64'(busy), 64'(0), "busy after reset");
        check(64'(sat_busy), 64'(0), "saturating build busy after reset");
        check(64'(peaks), 64'(0), "peaks after reset");
        check(64'(sat_peaks), 64'(0), "saturating build peaks after reset");

        make_random_frame();
        run_frame(1'b0, 1'b0);
        run_frame(1'b1, 1'b0);    // Same words with idle cycles in between.
        make_tie_frame();
        run_frame(1'b0, 1'b0);
        make_random_frame();
        run_frame(1'b0, 1'b0);
        make_random_frame();
        run_frame(1'b0, 1'b1);    // Extra words while draining and scanning.
        make_sat_frame();
        run_frame(1'b0, 1'b0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== sifh_top.f ====
verilog/sifh_geometry_pkg.sv
verilog/sifh_ctrl_pkg.sv
verilog/sifh_control.sv
verilog/hist_bank.sv
verilog/peak_finder.sv
verilog/sifh_top.sv
test/sifh_properties.sv
test/sifh_top_tb.sv

// ==== Makefile ====
# Verilator flow for the photon arrival histogram block.

TOP = sifh_top_tb
LOG = sim.log

.PHONY: all build run lint clean

all: build run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sifh_top.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sifh_top.f

clean:
	rm -rf obj_dir $(LOG)
